// File: ahb_input_stage.f
+incdir+sim
verilog/ahb_is_pkg.sv
verilog/ahb_addr_decode.sv
verilog/ahb_hold_reg.sv
verilog/ahb_burst_term.sv
verilog/ahb_resp_gen.sv
verilog/ahb_input_stage.sv
sim/tb_ahb_input_stage.sv

// File: sim/ahb_is_tb_tasks.svh
// Drive, compare and directed test tasks for the AHB input stage
// testbench, included inside the testbench top

// ----------------------------------------
// Drive
// ----------------------------------------
// Next address phase, driven on the rising edge
task automatic drive_addr_phase(input logic [TRANS_W-1:0] trans,
                                input logic [ADDR_W-1:0]  addr,
                                input logic [BURST_W-1:0] burst,
                                input logic               ready);
  @(posedge HCLK);
  HSELS   <= (trans != TRN_IDLE);
  HTRANSS <= trans;
  HADDRS  <= addr;
  HBURSTS <= burst;
  HWRITES <= (trans != TRN_IDLE);  // IDLE beats read, so held writes stand out
  HREADYS <= ready;                // Bus HREADY as the master sees it
endtask

// Output stage side, on the edge the caller is at
task automatic set_slave(input logic active, input logic ready,
                         input logic [RESP_W-1:0] resp);
  active_ip   <= active;
  readyout_ip <= ready;
  resp_ip     <= resp;
endtask

// Grant with the slave ready, then wait for held_tran_ip to fall
task automatic release_held();
  int n;
  @(posedge HCLK);
  set_slave(1'b1, 1'b1, RSP_OKAY);
  for (n = 0; n < 8; n++)
  begin
    @(negedge HCLK);
    if (!held_tran_ip)
      break;
  end
  if (held_tran_ip)
  begin
    errors++;
    $display("Held transfer was not released within 8 cycles of the grant");
  end
endtask

// ----------------------------------------
// Compare
// ----------------------------------------
task automatic report_mismatch(input string name, input logic [ADDR_W-1:0] exp, act);
  errors++;
  $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act);
endtask

task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp, act);
  if (act !== exp)
    report_mismatch(name, exp, act);
endtask

task automatic check_trans(input string name, input logic [TRANS_W-1:0] exp, act);
  if (act !== exp)
    report_mismatch(name, exp, act);
endtask

task automatic check_burst(input string name, input logic [BURST_W-1:0] exp, act);
  if (act !== exp)
    report_mismatch(name, exp, act);
endtask

task automatic check_size(input string name, input logic [SIZE_W-1:0] exp, act);
  if (act !== exp)
    report_mismatch(name, exp, act);
endtask

task automatic check_prot(input string name, input logic [PROT_W-1:0] exp, act);
  if (act !== exp)
    report_mismatch(name, exp, act);
endtask

task automatic check_resp(input string name, input logic [RESP_W-1:0] exp, act);
  if (act !== exp)
    report_mismatch(name, exp, act);
endtask

task automatic check_bit(input string name, input logic exp, act);
  if (act !== exp)
    report_mismatch(name, exp, act);
endtask

// Address, rewritten controls and arbiter request of the shown beat
task automatic check_outputs(input logic [ADDR_W-1:0]  addr,
                             input logic [TRANS_W-1:0] trans,
                             input logic [BURST_W-1:0] burst,
                             input logic               held);
  check_addr("addr_ip", addr, addr_ip);
  check_trans("trans_ip", trans, trans_ip);
  check_burst("burst_ip", burst, burst_ip);
  check_bit("held_tran_ip", held, held_tran_ip);
endtask

// Size, protection and lock of the shown beat
task automatic check_attrs(input logic [SIZE_W-1:0] size,
                           input logic [PROT_W-1:0] prot,
                           input logic              lock);
  check_size("size_ip", size, size_ip);
  check_prot("prot_ip", prot, prot_ip);
  check_bit("mastlock_ip", lock, mastlock_ip);
endtask

// ----------------------------------------
// Directed tests
// ----------------------------------------
task automatic test_reset();
  @(negedge HCLK);
  check_bit("HREADYOUTS", 1'b1, HREADYOUTS);
  check_resp("HRESPS", RSP_OKAY, HRESPS);
  check_bit("held_tran_ip", 1'b0, held_tran_ip);
endtask

task automatic test_pass(input logic [RESP_W-1:0] resp, input logic ready);
  logic [ADDR_W-1:0] a;
  a = $urandom & 32'hFFFF_FFFC;  // Word aligned
  drive_addr_phase(TRN_NONSEQ, a, BUR_SINGLE, 1'b1);
  set_slave(1'b1, 1'b1, RSP_OKAY);
  @(negedge HCLK);
  check_outputs(a, TRN_NONSEQ, BUR_SINGLE, 1'b1);  // Same cycle
  check_bit("sel_ip", 1'b1, sel_ip);
  check_bit("write_ip", 1'b1, write_ip);
  check_attrs(SZ_32, 4'h3, 1'b0);
  drive_addr_phase(TRN_IDLE, a + 4, BUR_SINGLE, 1'b1);
  set_slave(1'b1, ready, resp);                    // Data phase response
  @(negedge HCLK);
  check_bit("HREADYOUTS", ready, HREADYOUTS);
  check_resp("HRESPS", resp, HRESPS);
endtask

task automatic test_held();
  logic [ADDR_W-1:0] a;
  a = $urandom & 32'hFFFF_FFFC;
  drive_addr_phase(TRN_NONSEQ, a, BUR_SINGLE, 1'b1);
  set_slave(1'b0, 1'b1, RSP_OKAY);                  // No grant
  drive_addr_phase(TRN_IDLE, ~a, BUR_INCR8, 1'b0);   // Master waits on HREADY
  HSIZES     <= SZ_8;                                // Live controls differ from held
  HPROTS     <= 4'hC;
  HMASTLOCKS <= 1'b1;
  @(negedge HCLK);
  check_outputs(a, TRN_NONSEQ, BUR_SINGLE, 1'b1);
  check_bit("sel_ip", 1'b1, sel_ip);
  check_bit("write_ip", 1'b1, write_ip);
  check_attrs(SZ_32, 4'h3, 1'b0);
  check_bit("HREADYOUTS", 1'b0, HREADYOUTS);
  release_held();
  check_outputs(~a, TRN_IDLE, BUR_INCR8, 1'b0);      // Live inputs again
  check_attrs(SZ_8, 4'hC, 1'b1);
  check_bit("HREADYOUTS", 1'b1, HREADYOUTS);
  @(posedge HCLK);
  HSIZES     <= SZ_32;                               // Back to word beats
  HPROTS     <= 4'h3;
  HMASTLOCKS <= 1'b0;
endtask

task automatic test_backpressure();
  logic [ADDR_W-1:0] a;
  a = $urandom & 32'hFFFF_FFFC;
  drive_addr_phase(TRN_NONSEQ, a, BUR_SINGLE, 1'b1);
  set_slave(1'b0, 1'b1, RSP_OKAY);
  drive_addr_phase(TRN_IDLE, a + 32'h10, BUR_SINGLE, 1'b0);
  set_slave(1'b1, 1'b0, RSP_OKAY);  // Granted, slave not ready
  repeat (4)
  begin
    @(negedge HCLK);
    check_outputs(a, TRN_NONSEQ, BUR_SINGLE, 1'b1);
    check_bit("HREADYOUTS", 1'b0, HREADYOUTS);
  end
  release_held();
endtask

task automatic test_burst_rewrite();
  logic [ADDR_W-1:0] a;
  a = $urandom & 32'hFFFF_FFF0;
  drive_addr_phase(TRN_NONSEQ, a, BUR_INCR4, 1'b1);
  set_slave(1'b1, 1'b1, RSP_OKAY);
  drive_addr_phase(TRN_SEQ, a + 4, BUR_INCR4, 1'b1);
  set_slave(1'b0, 1'b1, RSP_OKAY);                   // Grant lost mid burst
  drive_addr_phase(TRN_SEQ, a + 8, BUR_INCR4, 1'b0);
  @(negedge HCLK);
  check_outputs(a + 4, TRN_NONSEQ, BUR_INCR, 1'b1);  // Held SEQ restarts as INCR
  release_held();
  check_outputs(a + 8, TRN_SEQ, BUR_INCR, 1'b0);
  drive_addr_phase(TRN_IDLE, a, BUR_SINGLE, 1'b1);   // Ends the burst
endtask

// SEQ beat at word offset beat of a WRAP4 window is held, the next beat checked
task automatic test_wrap(input int beat, input logic [TRANS_W-1:0] exp_trans);
  logic [ADDR_W-1:0] base;
  base = $urandom & 32'hFFFF_FFF0;  // Start of a 16-byte window
  drive_addr_phase(TRN_NONSEQ, base + 4 * (beat - 1), BUR_WRAP4, 1'b1);
  set_slave(1'b1, 1'b1, RSP_OKAY);
  drive_addr_phase(TRN_SEQ, base + 4 * beat, BUR_WRAP4, 1'b1);
  set_slave(1'b0, 1'b1, RSP_OKAY);
  drive_addr_phase(TRN_SEQ, base + 4 * ((beat + 1) % 4), BUR_WRAP4, 1'b0);
  release_held();
  check_outputs(base + 4 * ((beat + 1) % 4), exp_trans, BUR_INCR, 1'b0);
  drive_addr_phase(TRN_IDLE, base, BUR_SINGLE, 1'b1);
endtask

// File: sim/tb_ahb_input_stage.sv
// Testbench top for the AHB input stage with clock, reset,
// watchdog, DUT instance and the directed test sequence

`timescale 1ns/1ps

module tb_ahb_input_stage;

  import ahb_is_pkg::*;

  localparam int CLK_PERIOD  = 8;
  // Reset, pass x2, held, back-pressure, burst, wrap x2, tail
  localparam int TEST_CYCLES = 6 + 2 * 4 + 8 + 12 + 10 + 2 * 9 + 2;

  // Master side
  logic               HCLK       = 1'b0;
  logic               HRESETn    = 1'b0;
  logic               HSELS      = 1'b0;
  logic [ADDR_W-1:0]  HADDRS     = '0;
  logic [TRANS_W-1:0] HTRANSS    = TRN_IDLE;
  logic               HWRITES    = 1'b0;
  logic [SIZE_W-1:0]  HSIZES     = SZ_32;   // Word beats throughout
  logic [BURST_W-1:0] HBURSTS    = BUR_SINGLE;
  logic [PROT_W-1:0]  HPROTS     = 4'h3;
  logic               HMASTLOCKS = 1'b0;
  logic               HREADYS    = 1'b1;
  logic               HREADYOUTS;
  logic [RESP_W-1:0]  HRESPS;
  // Output stage side
  logic               active_ip   = 1'b0;
  logic               readyout_ip = 1'b1;
  logic [RESP_W-1:0]  resp_ip     = RSP_OKAY;
  logic               sel_ip;
  logic [ADDR_W-1:0]  addr_ip;
  logic [TRANS_W-1:0] trans_ip;
  logic               write_ip;
  logic [SIZE_W-1:0]  size_ip;
  logic [BURST_W-1:0] burst_ip;
  logic [PROT_W-1:0]  prot_ip;
  logic               mastlock_ip;
  logic               held_tran_ip;

  int errors = 0;  // Bumped by every failed check

  ahb_input_stage ahb_input_stage_inst (.*);

  // ----------------------------------------
  // Clock and watchdog
  // ----------------------------------------
  initial
  begin
    forever
      #(CLK_PERIOD / 2) HCLK = ~HCLK;
  end

  initial
  begin
    #(CLK_PERIOD * TEST_CYCLES * 2);  // Twice the expected run
    $display("Watchdog expired after %0d ns, a test did not finish",
             CLK_PERIOD * TEST_CYCLES * 2);
    $display("Simulation failed");
    $finish;
  end

  `include "ahb_is_tb_tasks.svh"

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial
  begin
    void'($urandom(86491));  // One seed for all addresses
    repeat (5) @(posedge HCLK);
    HRESETn <= 1'b1;
    test_reset();
    test_pass(RSP_OKAY, 1'b0);   // Slave inserts a wait state
    test_pass(RSP_ERROR, 1'b1);
    test_held();
    test_backpressure();
    test_burst_rewrite();
    test_wrap(3, TRN_NONSEQ);  // Last beat of the window, next beat jumps back
    test_wrap(1, TRN_SEQ);     // Mid window, burst may continue as SEQ
    repeat (2) @(posedge HCLK);
    $display("Checks finished with %0d errors", errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: verilog/ahb_addr_decode.sv
// Address-phase qualification, holding register load strobe
// and registered wrap-boundary flag

`timescale 1ns/1ps

module ahb_addr_decode (
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  logic                          HSELS,
  input  logic [ahb_is_pkg::ADDR_W-1:0]  HADDRS,
  input  logic [ahb_is_pkg::TRANS_W-1:0] HTRANSS,
  input  logic [ahb_is_pkg::SIZE_W-1:0]  HSIZES,
  input  logic [ahb_is_pkg::BURST_W-1:0] HBURSTS,
  input  logic                          HREADYS,
  output logic                          addr_valid,  // Active transfer to this port
  output logic                          load_reg,    // Capture into holding register
  output logic                          bound        // Beat sits at wrap boundary
);

  import ahb_is_pkg::*;

  logic [OFFS_W-1:0] offset_addr;  // Beat number within the wrap window
  logic [OFFS_W-1:0] check_addr;   // Offset padded with ones for short wraps
  logic              bound_next;
  logic              bound_en;

  // --------------------------------------
  // Address phase qualification
  // --------------------------------------
  // NONSEQ or SEQ only, IDLE and BUSY need no slave action
  assign addr_valid = HSELS & ((HTRANSS == TRN_NONSEQ) | (HTRANSS == TRN_SEQ));
  assign load_reg   = addr_valid & HREADYS;  // Master has finished previous beat

  // --------------------------------------
  // Wrap boundary detection
  // --------------------------------------
  always_comb
  begin
    case (HSIZES)
      SZ_8    : offset_addr = HADDRS[3:0];
      SZ_16   : offset_addr = HADDRS[4:1];
      SZ_32   : offset_addr = HADDRS[5:2];
      SZ_64   : offset_addr = HADDRS[6:3];
      default : offset_addr = HADDRS[3:0];  // Wider beats handled as bytes
    endcase
  end

  // Upper bits forced high so only the wrap length is compared
  always_comb
  begin
    case (HBURSTS)
      BUR_WRAP4  : check_addr = {2'b11, offset_addr[1:0]};
      BUR_WRAP8  : check_addr = {1'b1, offset_addr[2:0]};
      BUR_WRAP16 : check_addr = offset_addr;
      default    : check_addr = '0;  // Incrementing and single never wrap
    endcase
  end

  assign bound_next = &check_addr;           // Last beat before the wrap
  assign bound_en   = HTRANSS[1] & HREADYS;  // Sampled on accepted NONSEQ/SEQ only

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (bound_en)
      bound <= bound_next;
  end

  // Address and control of a valid beat are never X
  a_valid_beat_known : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    addr_valid |-> !$isunknown({HADDRS, HSIZES, HBURSTS})
  );

endmodule

// File: verilog/ahb_burst_term.sv
// Early burst termination, rewriting HBURST to INCR and
// SEQ/BUSY to NONSEQ/IDLE for an interrupted burst

`timescale 1ns/1ps

module ahb_burst_term (
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  logic [ahb_is_pkg::TRANS_W-1:0] HTRANSS,
  input  logic                          HREADYS,
  input  logic                          load_reg,
  input  logic                          active_ip,
  input  logic                          bound,      // Wrap boundary of last beat
  input  logic [ahb_is_pkg::TRANS_W-1:0] trans_int,
  input  logic [ahb_is_pkg::BURST_W-1:0] burst_int,
  input  logic [ahb_is_pkg::TRANS_W-1:0] transb,
  output logic [ahb_is_pkg::TRANS_W-1:0] trans_ip,
  output logic [ahb_is_pkg::BURST_W-1:0] burst_ip
);

  import ahb_is_pkg::*;

  logic burst_override;       // Current burst lost the output stage
  logic burst_override_next;

  // --------------------------------------
  // Override tracking
  // --------------------------------------
  // A SEQ beat parked in the holding register means the slave saw the
  // burst broken, so the rest of it is sent as an INCR burst
  always_comb
  begin
    if ((HTRANSS == TRN_NONSEQ) || (HTRANSS == TRN_IDLE))
      burst_override_next = 1'b0;  // Burst over
    else if ((HTRANSS == TRN_SEQ) && load_reg && !active_ip)
      burst_override_next = 1'b1;
    else
      burst_override_next = burst_override;  // BUSY keeps state
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      burst_override <= 1'b0;
    else if (HREADYS)
      burst_override <= burst_override_next;
  end

  // --------------------------------------
  // HTRANS / HBURST rewrite
  // --------------------------------------
  // Past a wrap boundary the address jumps back, so the next beat
  // cannot be SEQ of an INCR burst. Clearing bit 0 gives NONSEQ or IDLE
  assign trans_ip = (burst_override && bound) ? {trans_int[1], 1'b0}
                                              : trans_int;

  // First NONSEQ of a new burst keeps its own HBURST
  assign burst_ip = (burst_override && (transb != TRN_NONSEQ)) ? BUR_INCR
                                                               : burst_int;

endmodule

// File: verilog/ahb_hold_reg.sv
// Holding register, pending-transfer flag and the mux
// between the live and the held address phase

`timescale 1ns/1ps

module ahb_hold_reg (
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  logic                          load_reg,
  input  logic                          active_ip,    // Output stage grant
  input  logic                          readyout_ip,  // Output stage ready
  input  logic                          HSELS,
  input  logic [ahb_is_pkg::ADDR_W-1:0]  HADDRS,
  input  logic [ahb_is_pkg::TRANS_W-1:0] HTRANSS,
  input  logic                          HWRITES,
  input  logic [ahb_is_pkg::SIZE_W-1:0]  HSIZES,
  input  logic [ahb_is_pkg::BURST_W-1:0] HBURSTS,
  input  logic [ahb_is_pkg::PROT_W-1:0]  HPROTS,
  input  logic                          HMASTLOCKS,
  output logic                          pend_tran_reg,  // Holding register in use
  output logic                          held_tran_ip,   // Request to arbiter
  output logic                          sel_ip,
  output logic [ahb_is_pkg::ADDR_W-1:0]  addr_ip,
  output logic [ahb_is_pkg::TRANS_W-1:0] trans_int,     // Before burst rewrite
  output logic                          write_ip,
  output logic [ahb_is_pkg::SIZE_W-1:0]  size_ip,
  output logic [ahb_is_pkg::BURST_W-1:0] burst_int,     // Before burst rewrite
  output logic [ahb_is_pkg::PROT_W-1:0]  prot_ip,
  output logic                          mastlock_ip,
  output logic [ahb_is_pkg::TRANS_W-1:0] transb         // Original HTRANS of shown beat
);

  import ahb_is_pkg::*;

  logic [TRANS_W-1:0] reg_trans;
  logic [ADDR_W-1:0]  reg_addr;
  logic               reg_write;
  logic [SIZE_W-1:0]  reg_size;
  logic [BURST_W-1:0] reg_burst;
  logic [PROT_W-1:0]  reg_prot;
  logic               reg_mastlock;
  logic               pend_tran;  // Next state of pend_tran_reg

  // --------------------------------------
  // Holding register
  // --------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      reg_trans    <= TRN_IDLE;
      reg_addr     <= '0;
      reg_write    <= 1'b0;
      reg_size     <= '0;
      reg_burst    <= BUR_SINGLE;
      reg_prot     <= '0;
      reg_mastlock <= 1'b0;
    end
    else if (load_reg)  // Every accepted beat, granted or not
    begin
      reg_trans    <= HTRANSS;
      reg_addr     <= HADDRS;
      reg_write    <= HWRITES;
      reg_size     <= HSIZES;
      reg_burst    <= HBURSTS;
      reg_prot     <= HPROTS;
      reg_mastlock <= HMASTLOCKS;
    end
  end

  // --------------------------------------
  // Pending transfer flag
  // --------------------------------------
  // Set when a beat arrives with no grant, cleared once the output
  // stage has the beat and the slave is ready
  always_comb
  begin
    if (load_reg && !active_ip)
      pend_tran = 1'b1;
    else if (active_ip && readyout_ip)
      pend_tran = 1'b0;
    else
      pend_tran = pend_tran_reg;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_tran_reg <= 1'b0;
    else
      pend_tran_reg <= pend_tran;
  end

  assign held_tran_ip = load_reg | pend_tran_reg;  // Live or held request

  // --------------------------------------
  // Live / held output mux
  // --------------------------------------
  always_comb
  begin
    if (!pend_tran_reg)
    begin
      sel_ip      = HSELS;  // Straight through
      trans_int   = HTRANSS;
      addr_ip     = HADDRS;
      write_ip    = HWRITES;
      size_ip     = HSIZES;
      burst_int   = HBURSTS;
      prot_ip     = HPROTS;
      mastlock_ip = HMASTLOCKS;
      transb      = HTRANSS;
    end
    else
    begin
      sel_ip      = 1'b1;        // Held beat is always for this port
      trans_int   = TRN_NONSEQ;  // Restarts as a new transfer at the slave
      addr_ip     = reg_addr;
      write_ip    = reg_write;
      size_ip     = reg_size;
      burst_int   = reg_burst;
      prot_ip     = reg_prot;
      mastlock_ip = reg_mastlock;
      transb      = reg_trans;   // Keeps SEQ so the burst can be rewritten
    end
  end

  // Master waits on the held beat, so the register is not reloaded
  a_no_load_while_held : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    pend_tran_reg |-> !load_reg
  );

endmodule

// File: verilog/ahb_input_stage.sv
// AHB-Lite bus matrix input stage, top level with address decode,
// holding register, burst termination and response

`timescale 1ns/1ps

module ahb_input_stage (
  input  logic                          HCLK,
  input  logic                          HRESETn,
  // Master side
  input  logic                          HSELS,
  input  logic [ahb_is_pkg::ADDR_W-1:0]  HADDRS,
  input  logic [ahb_is_pkg::TRANS_W-1:0] HTRANSS,
  input  logic                          HWRITES,
  input  logic [ahb_is_pkg::SIZE_W-1:0]  HSIZES,
  input  logic [ahb_is_pkg::BURST_W-1:0] HBURSTS,
  input  logic [ahb_is_pkg::PROT_W-1:0]  HPROTS,
  input  logic                          HMASTLOCKS,
  input  logic                          HREADYS,
  output logic                          HREADYOUTS,
  output logic [ahb_is_pkg::RESP_W-1:0]  HRESPS,
  // Output stage side
  input  logic                          active_ip,
  input  logic                          readyout_ip,
  input  logic [ahb_is_pkg::RESP_W-1:0]  resp_ip,
  output logic                          sel_ip,
  output logic [ahb_is_pkg::ADDR_W-1:0]  addr_ip,
  output logic [ahb_is_pkg::TRANS_W-1:0] trans_ip,
  output logic                          write_ip,
  output logic [ahb_is_pkg::SIZE_W-1:0]  size_ip,
  output logic [ahb_is_pkg::BURST_W-1:0] burst_ip,
  output logic [ahb_is_pkg::PROT_W-1:0]  prot_ip,
  output logic                          mastlock_ip,
  output logic                          held_tran_ip
);

  import ahb_is_pkg::*;

  logic               load_reg;
  logic               addr_valid;
  logic               bound;
  logic               pend_tran_reg;
  logic [TRANS_W-1:0] trans_int;  // Mux output ahead of rewrite
  logic [BURST_W-1:0] burst_int;
  logic [TRANS_W-1:0] transb;

  // --------------------------------------
  // Decode
  // --------------------------------------
  ahb_addr_decode ahb_addr_decode_inst (
    .HCLK, .HRESETn, .HSELS, .HADDRS, .HTRANSS, .HSIZES, .HBURSTS, .HREADYS,
    .addr_valid, .load_reg, .bound
  );

  // --------------------------------------
  // Execute
  // --------------------------------------
  ahb_hold_reg ahb_hold_reg_inst (
    .HCLK, .HRESETn, .load_reg, .active_ip, .readyout_ip,
    .HSELS, .HADDRS, .HTRANSS, .HWRITES, .HSIZES, .HBURSTS, .HPROTS, .HMASTLOCKS,
    .pend_tran_reg, .held_tran_ip, .sel_ip, .addr_ip, .trans_int, .write_ip,
    .size_ip, .burst_int, .prot_ip, .mastlock_ip, .transb
  );

  ahb_burst_term ahb_burst_term_inst (
    .HCLK, .HRESETn, .HTRANSS, .HREADYS, .load_reg, .active_ip, .bound,
    .trans_int, .burst_int, .transb, .trans_ip, .burst_ip
  );

  // --------------------------------------
  // Result
  // --------------------------------------
  ahb_resp_gen ahb_resp_gen_inst (
    .HCLK, .HRESETn, .addr_valid, .HREADYS, .pend_tran_reg,
    .readyout_ip, .resp_ip, .HREADYOUTS, .HRESPS
  );

endmodule

// File: verilog/ahb_is_pkg.sv
// Bus widths and the HTRANS, HBURST, HSIZE and HRESP codes
// shared by the AHB input stage

package ahb_is_pkg;

  // --------------------------------------
  // Bus widths
  // --------------------------------------
  localparam int ADDR_W  = 32;  // HADDR
  localparam int TRANS_W = 2;   // HTRANS
  localparam int BURST_W = 3;   // HBURST
  localparam int SIZE_W  = 3;   // HSIZE
  localparam int PROT_W  = 4;   // HPROT
  localparam int RESP_W  = 2;   // HRESP, AHB-Lite uses bit 0 only

  localparam int OFFS_W  = 4;   // Beat offset for wrap check, up to 16 beats

  // --------------------------------------
  // HTRANS codes
  // --------------------------------------
  localparam logic [TRANS_W-1:0] TRN_IDLE   = 2'b00;
  localparam logic [TRANS_W-1:0] TRN_BUSY   = 2'b01;
  localparam logic [TRANS_W-1:0] TRN_NONSEQ = 2'b10;
  localparam logic [TRANS_W-1:0] TRN_SEQ    = 2'b11;

  // HBURST codes
  localparam logic [BURST_W-1:0] BUR_SINGLE = 3'b000;
  localparam logic [BURST_W-1:0] BUR_INCR   = 3'b001;  // Undefined length
  localparam logic [BURST_W-1:0] BUR_WRAP4  = 3'b010;
  localparam logic [BURST_W-1:0] BUR_INCR4  = 3'b011;
  localparam logic [BURST_W-1:0] BUR_WRAP8  = 3'b100;
  localparam logic [BURST_W-1:0] BUR_INCR8  = 3'b101;
  localparam logic [BURST_W-1:0] BUR_WRAP16 = 3'b110;
  localparam logic [BURST_W-1:0] BUR_INCR16 = 3'b111;

  // HSIZE codes handled by the wrap check
  localparam logic [SIZE_W-1:0]  SZ_8       = 3'b000;
  localparam logic [SIZE_W-1:0]  SZ_16      = 3'b001;
  localparam logic [SIZE_W-1:0]  SZ_32      = 3'b010;
  localparam logic [SIZE_W-1:0]  SZ_64      = 3'b011;

  // --------------------------------------
  // HRESP codes
  // --------------------------------------
  localparam logic [RESP_W-1:0]  RSP_OKAY   = 2'b00;
  localparam logic [RESP_W-1:0]  RSP_ERROR  = 2'b01;

endpackage

// File: verilog/ahb_resp_gen.sv
// Data-phase tracking and HREADYOUTS/HRESPS selection

`timescale 1ns/1ps

module ahb_resp_gen (
  input  logic                         HCLK,
  input  logic                         HRESETn,
  input  logic                         addr_valid,
  input  logic                         HREADYS,
  input  logic                         pend_tran_reg,
  input  logic                         readyout_ip,  // From output stage
  input  logic [ahb_is_pkg::RESP_W-1:0] resp_ip,      // From output stage
  output logic                         HREADYOUTS,
  output logic [ahb_is_pkg::RESP_W-1:0] HRESPS
);

  import ahb_is_pkg::*;

  logic data_valid;  // Data phase of an active transfer

  // --------------------------------------
  // Data phase tracking
  // --------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (HREADYS)  // Address phase completes
      data_valid <= addr_valid;
  end

  // --------------------------------------
  // Response selection
  // --------------------------------------
  always_comb
  begin
    if (!data_valid)
    begin
      HREADYOUTS = 1'b1;      // Idle, busy or not selected
      HRESPS     = RSP_OKAY;
    end
    else if (pend_tran_reg)
    begin
      HREADYOUTS = 1'b0;      // Wait state while beat is held
      HRESPS     = RSP_OKAY;
    end
    else
    begin
      HREADYOUTS = readyout_ip;
      HRESPS     = resp_ip;
    end
  end

  // Held beat keeps its data phase open until released
  a_held_in_data_phase : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    pend_tran_reg |-> data_valid
  );

endmodule
